// ==== logic/mmioDecode.sv ====
//************************************************************
// address and load/store decode for the MMIO block
// purely combinational, strobes are high for the access cycle
// stall forces every output inactive, nothing else sees stall
//************************************************************

`timescale 1ns/1ps
`default_nettype none

module mmioDecode (
	input  logic [mmioPkg::DATA_W-1:0] addr,     // cpu address
	input  mmioPkg::ldStOp_e           ldStCtrl, // opcode class
	input  logic                       memToReg, // load result written back
	input  logic                       stall,    // pipeline held
	output mmioPkg::mmioCmd_t          cmd
);

	import mmioPkg::*;

	mmioReg_e rawSel;  // select before stall gating
	logic     isStore; // SB/SH/SW

	// exact word match, anything else is unmapped
	always_comb begin
		case (addr)
			MMIO_TX_RDY:  rawSel = REG_TX_RDY;
			MMIO_RX_VLD:  rawSel = REG_RX_VLD;
			MMIO_TX_DATA: rawSel = REG_TX_DATA;
			MMIO_RX_DATA: rawSel = REG_RX_DATA;
			MMIO_CYCLES:  rawSel = REG_CYCLES;
			MMIO_INSTS:   rawSel = REG_INSTS;
			MMIO_CLEAR:   rawSel = REG_CLEAR;
			default:      rawSel = REG_NONE;
		endcase
	end

	// store width does not matter, only byte 0 goes out
	always_comb begin
		case (ldStCtrl)
			SB, SH, SW: isStore = 1'b1;
			default:    isStore = 1'b0;
		endcase
	end

	// stall gating for the whole block lives here
	always_comb begin
		if (stall) begin
			cmd.sel      = REG_NONE;
			cmd.txStart  = 1'b0;
			cmd.rxAck    = 1'b0;
			cmd.cntClear = 1'b0;
		end else begin
			cmd.sel      = rawSel;
			cmd.txStart  = (rawSel == REG_TX_DATA) && isStore;
			cmd.rxAck    = (rawSel == REG_RX_DATA) && memToReg; // consume only on real load
			cmd.cntClear = (rawSel == REG_CLEAR);               // load or store both clear
		end
	end

endmodule

`default_nettype wire

// ==== logic/mmioPkg.sv ====
//************************************************************
// shared types and the register map of the MMIO/UART block
// addresses are full 32-bit word addresses, exact match only
// opcode values 5..7 are the store class
//************************************************************

`default_nettype none

package mmioPkg;

	localparam int DATA_W = 32; // cpu word width

	// register map, one word apart
	localparam logic [DATA_W-1:0] MMIO_TX_RDY  = 32'h8000_0000; // tx ready status
	localparam logic [DATA_W-1:0] MMIO_RX_VLD  = 32'h8000_0004; // rx valid status
	localparam logic [DATA_W-1:0] MMIO_TX_DATA = 32'h8000_0008; // byte to send
	localparam logic [DATA_W-1:0] MMIO_RX_DATA = 32'h8000_000C; // received byte
	localparam logic [DATA_W-1:0] MMIO_CYCLES  = 32'h8000_0010; // cycle count
	localparam logic [DATA_W-1:0] MMIO_INSTS   = 32'h8000_0014; // retired insts
	localparam logic [DATA_W-1:0] MMIO_CLEAR   = 32'h8000_0018; // counter clear

	// load/store control as the cpu encodes it
	typedef enum logic [2:0] {
		LB  = 3'd0,
		LH  = 3'd1,
		LW  = 3'd2,
		LBU = 3'd3,
		LHU = 3'd4,
		SB  = 3'd5, // stores from here up
		SH  = 3'd6,
		SW  = 3'd7
	} ldStOp_e;

	// register hit by the current access
	typedef enum logic [2:0] {
		REG_NONE,    // unmapped or stalled
		REG_TX_RDY,
		REG_RX_VLD,
		REG_TX_DATA,
		REG_RX_DATA,
		REG_CYCLES,
		REG_INSTS,
		REG_CLEAR
	} mmioReg_e;

	// decode result fanned out to execute and result stages
	typedef struct packed {
		mmioReg_e sel;      // already REG_NONE under stall
		logic     txStart;  // store to tx data
		logic     rxAck;    // load of rx data into a register
		logic     cntClear; // any access to the clear word
	} mmioCmd_t;

endpackage

`default_nettype wire

// ==== logic/mmioReadMux.sv ====
//************************************************************
// read data for the MMIO registers, purely combinational
// status bits and the rx byte come back zero extended
// write-only and unmapped words read as zero
//************************************************************

`timescale 1ns/1ps
`default_nettype none

module mmioReadMux (
	input  mmioPkg::mmioReg_e          sel,     // REG_NONE when stalled
	input  logic                       txReady,
	input  logic                       rxValid,
	input  logic [7:0]                 rxByte,
	input  logic [mmioPkg::DATA_W-1:0] cycles,
	input  logic [mmioPkg::DATA_W-1:0] insts,
	output logic [mmioPkg::DATA_W-1:0] rdData
);

	import mmioPkg::*;

	always_comb begin
		case (sel)
			REG_TX_RDY: begin
				rdData = {{(DATA_W-1){1'b0}}, txReady};
			end
			REG_RX_VLD: begin
				rdData = {{(DATA_W-1){1'b0}}, rxValid};
			end
			REG_RX_DATA: begin
				rdData = {{(DATA_W-8){1'b0}}, rxByte}; // no byte-lane shift
			end
			REG_CYCLES: begin
				rdData = cycles;
			end
			REG_INSTS: begin
				rdData = insts;
			end
			// tx data and clear are write side only
			default: begin
				rdData = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/mmioUartTop.sv ====
//************************************************************
// memory-stage MMIO block: UART tx/rx plus two perf counters
// rdData is combinational from addr and stall
// only wrData[7:0] is sent, sub-word loads are not lane shifted
// CLKS_PER_BIT of 4 or more
//************************************************************

`timescale 1ns/1ps
`default_nettype none

module mmioUartTop #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [mmioPkg::DATA_W-1:0] addr,
	input  logic [7:0]                 wrData,     // tx byte
	input  mmioPkg::ldStOp_e           ldStCtrl,
	input  logic                       memToReg,
	input  logic                       stall,
	input  logic                       instRetire, // pulse per retired inst
	output logic [mmioPkg::DATA_W-1:0] rdData,
	input  logic                       rxd,
	output logic                       txd
);

	import mmioPkg::*;

	mmioCmd_t          cmd;     // decode result
	logic              txReady;
	logic              rxValid;
	logic [7:0]        rxByte;
	logic [DATA_W-1:0] cycles;
	logic [DATA_W-1:0] insts;

	// decode
	mmioDecode decode_i (
		.addr     (addr),
		.ldStCtrl (ldStCtrl),
		.memToReg (memToReg),
		.stall    (stall),
		.cmd      (cmd)
	);

	// execute
	uartTx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) uartTx_i (
		.clk     (clk),
		.rst     (rst),
		.txStart (cmd.txStart),
		.txByte  (wrData),
		.txReady (txReady),
		.txd     (txd)
	);

	uartRx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) uartRx_i (
		.clk     (clk),
		.rst     (rst),
		.rxd     (rxd),
		.rxAck   (cmd.rxAck),
		.rxValid (rxValid),
		.rxByte  (rxByte)
	);

	perfCounters counters_i (
		.clk        (clk),
		.rst        (rst),
		.instRetire (instRetire),
		.cntClear   (cmd.cntClear),
		.cycles     (cycles),
		.insts      (insts)
	);

	// result
	mmioReadMux readMux_i (
		.sel     (cmd.sel),
		.txReady (txReady),
		.rxValid (rxValid),
		.rxByte  (rxByte),
		.cycles  (cycles),
		.insts   (insts),
		.rdData  (rdData)
	);

endmodule

`default_nettype wire

// ==== logic/perfCounters.sv ====
//************************************************************
// cycle and retired-instruction counters
// both wrap at 2^32, clear has priority over counting
// clear takes effect at the next edge
//************************************************************

`timescale 1ns/1ps
`default_nettype none

module perfCounters (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       instRetire, // one pulse per retired inst
	input  logic                       cntClear,   // from decode, already stall gated
	output logic [mmioPkg::DATA_W-1:0] cycles,
	output logic [mmioPkg::DATA_W-1:0] insts
);

	always_ff @(posedge clk) begin
		if (rst) begin
			cycles <= '0;
			insts  <= '0;
		end else if (cntClear) begin
			cycles <= '0; // both go together
			insts  <= '0;
		end else begin
			cycles <= cycles + 1'b1; // free running
			if (instRetire)
				insts <= insts + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/uartRx.sv ====
//************************************************************
// 8N1 receiver with 2-flop input sync and mid-bit sampling
// one byte of storage, a new frame overwrites an unread byte
// frames with a bad start or a low stop bit are dropped
//************************************************************

`timescale 1ns/1ps
`default_nettype none

module uartRx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       rxd,     // async serial in
	input  logic       rxAck,   // byte consumed
	output logic       rxValid, // held until rxAck
	output logic [7:0] rxByte
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam int HALF  = CLKS_PER_BIT / 2 - 1; // start bit re-check point
	localparam int FULL  = CLKS_PER_BIT - 1;

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} rxState_e;

	rxState_e         state;
	logic [1:0]       rxSync;   // metastability stages
	logic             rxLine;   // synced line
	logic [CNT_W-1:0] bitCnt;
	logic [2:0]       bitIdx;
	logic [7:0]       shiftReg; // LSB arrives first
	logic             sampleNow;

	assign rxLine = rxSync[1];

	// half a bit into the start bit, a full bit after that
	assign sampleNow = (state == START) ? (bitCnt == CNT_W'(HALF))
	                                    : (bitCnt == CNT_W'(FULL));

	always_ff @(posedge clk) begin
		if (rst)
			rxSync <= 2'b11; // line idles high
		else
			rxSync <= {rxSync[0], rxd};
	end

	always_ff @(posedge clk) begin
		if (rst || state == IDLE || sampleNow)
			bitCnt <= '0;
		else
			bitCnt <= bitCnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			bitIdx  <= '0;
			rxValid <= 1'b0;
		end else begin
			if (rxAck)
				rxValid <= 1'b0; // a finishing frame below wins
			case (state)
				IDLE: begin
					bitIdx <= '0;
					if (!rxLine)
						state <= START; // falling edge seen
				end
				START: begin
					if (sampleNow)
						state <= rxLine ? IDLE : DATA; // glitch goes back to idle
				end
				DATA: begin
					if (sampleNow) begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7)
							state <= STOP;
					end
				end
				STOP: begin
					if (sampleNow) begin
						state <= IDLE;
						if (rxLine)
							rxValid <= 1'b1; // good stop bit
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// data path, no reset
	always_ff @(posedge clk) begin
		if (state == DATA && sampleNow)
			shiftReg <= {rxLine, shiftReg[7:1]};
		if (state == STOP && sampleNow && rxLine)
			rxByte <= shiftReg; // overwrites any unread byte
	end

endmodule

`default_nettype wire

// ==== logic/uartTx.sv ====
//************************************************************
// 8N1 transmitter, LSB first, no parity
// CLKS_PER_BIT must be 4 or more
// a start while txReady is low is ignored, caller must poll
//************************************************************

`timescale 1ns/1ps
`default_nettype none

module uartTx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       txStart, // accepted only when txReady
	input  logic [7:0] txByte,
	output logic       txReady,
	output logic       txd      // idles high
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} txState_e;

	txState_e         state;
	logic [CNT_W-1:0] bitCnt;   // cycles inside current bit
	logic [2:0]       bitIdx;   // data bit being sent
	logic [7:0]       shiftReg; // next data bit in [0]
	logic             bitDone;  // last cycle of a bit

	assign bitDone = (bitCnt == CNT_W'(CLKS_PER_BIT - 1));
	assign txReady = (state == IDLE); // drops at the accepting edge

	// bit timer, held at zero while idle
	always_ff @(posedge clk) begin
		if (rst || state == IDLE || bitDone)
			bitCnt <= '0;
		else
			bitCnt <= bitCnt + 1'b1;
	end

	// byte latched on accept, shifted as each bit is put out
	always_ff @(posedge clk) begin
		if (txReady && txStart)
			shiftReg <= txByte;
		else if (bitDone && (state == START || state == DATA))
			shiftReg <= shiftReg >> 1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= IDLE;
			bitIdx <= '0;
			txd    <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					bitIdx <= '0;
					if (txStart) begin
						txd   <= 1'b0; // start bit at the same edge
						state <= START;
					end
				end
				START: begin
					if (bitDone) begin
						txd   <= shiftReg[0]; // data bit 0
						state <= DATA;
					end
				end
				DATA: begin
					if (bitDone) begin
						if (bitIdx == 3'd7) begin
							txd   <= 1'b1; // stop bit
							state <= STOP;
						end else begin
							txd    <= shiftReg[0];
							bitIdx <= bitIdx + 1'b1;
						end
					end
				end
				STOP: begin
					if (bitDone)
						state <= IDLE; // ready again 10 bit times after start
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== mmioUartTop.f ====
logic/mmioPkg.sv
logic/mmioDecode.sv
logic/perfCounters.sv
logic/uartTx.sv
logic/uartRx.sv
logic/mmioReadMux.sv
logic/mmioUartTop.sv
tests/mmioUartTb.sv

// ==== tests/mmioUartTb.sv ====
//************************************************************
// directed testbench for the MMIO/UART block, CLKS_PER_BIT 16
// inputs change on rising edges, rdData sampled on falling
// one access per two cycles, the bus idles at address 0
//************************************************************

`timescale 1ns/1ps
`default_nettype none

module mmioUartTb;

	import mmioPkg::*;

	localparam int CLKS       = 16; // clocks per serial bit
	localparam int PERIOD_NS  = 40;
	localparam int FRAME_NS   = 10 * CLKS * PERIOD_NS;
	localparam int TIMEOUT_NS = 40 * FRAME_NS + 50 * CLKS * PERIOD_NS; // frame budget plus slack

	logic        clk;
	logic        rst;
	logic [31:0] addr;
	logic [7:0]  wrData;
	ldStOp_e     ldStCtrl;
	logic        memToReg;
	logic        stall;
	logic        instRetire;
	logic [31:0] rdData;
	logic        rxd;
	logic        txd;

	integer seed   = 32'h8203_44c2;
	int     errors = 0;
	int     checks = 0;
	int     tests  = 0;

	mmioUartTop #(
		.CLKS_PER_BIT (CLKS)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.addr       (addr),
		.wrData     (wrData),
		.ldStCtrl   (ldStCtrl),
		.memToReg   (memToReg),
		.stall      (stall),
		.instRetire (instRetire),
		.rdData     (rdData),
		.rxd        (rxd),
		.txd        (txd)
	);

	always #(PERIOD_NS / 2) clk = ~clk;

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
			errors++;
		end
	endtask

	// one access cycle, side effects land on the closing edge
	task automatic busCycle(input logic [31:0] a, input ldStOp_e op, input logic m2r,
			input logic [7:0] wd, output logic [31:0] data);
		@(posedge clk);
		addr     <= a;
		ldStCtrl <= op;
		memToReg <= m2r;
		wrData   <= wd;
		@(negedge clk);
		data = rdData; // comb read settled mid cycle
		@(posedge clk);
		addr     <= 32'h0; // back to unmapped
		ldStCtrl <= LW;
		memToReg <= 1'b0;
	endtask

	task automatic readReg(input logic [31:0] a, input logic m2r, output logic [31:0] data);
		busCycle(a, LW, m2r, 8'h00, data);
	endtask

	task automatic writeReg(input logic [31:0] a, input ldStOp_e op, input logic [7:0] wd);
		logic [31:0] unused;
		busCycle(a, op, 1'b0, wd, unused);
	endtask

	task automatic expectReg(input string name, input logic [31:0] a, input logic m2r,
			input logic [31:0] exp);
		logic [31:0] data;
		readReg(a, m2r, data);
		checkEq(name, data, exp);
	endtask

	// poll a status word until it reads 1
	task automatic waitReg(input string name, input logic [31:0] a, input int maxPolls);
		logic [31:0] data;
		int          n;
		logic        seen;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < maxPolls) begin
			readReg(a, 1'b0, data);
			seen = (data == 32'h1);
			n++;
		end
		checks++;
		assert (seen) else begin
			$display("%s did not read 1 within %0d polls", name, maxPolls);
			errors++;
		end
	endtask

	// 8N1 frame onto rxd, LSB first
	task automatic sendRx(input logic [7:0] b);
		logic [9:0] frame;
		int         i;
		frame = {1'b1, b, 1'b0}; // stop, data, start
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			rxd <= frame[i];
			repeat (CLKS - 1) @(posedge clk);
		end
	endtask

	// recover a byte from txd, sampling each bit at its middle
	task automatic recvTx(output logic [7:0] b);
		int   waitCnt;
		int   i;
		logic seen;
		b       = '0;
		seen    = 1'b0;
		waitCnt = 0;
		while (!seen && waitCnt < 4 * CLKS) begin
			@(negedge clk);
			seen = (txd === 1'b0);
			waitCnt++;
		end
		checks++;
		assert (seen) else begin
			$display("no start bit on txd within %0d cycles", 4 * CLKS);
			errors++;
		end
		if (seen) begin
			repeat (CLKS / 2) @(negedge clk); // middle of start bit
			checkEq("txd start bit", txd, 1'b0);
			for (i = 0; i < 8; i++) begin
				repeat (CLKS) @(negedge clk);
				b[i] = txd;
			end
			repeat (CLKS) @(negedge clk);
			checkEq("txd stop bit", txd, 1'b1);
		end
	endtask

	task automatic expectTxIdle(input string what, input int cycles);
		int bad;
		bad = 0;
		repeat (cycles) begin
			@(negedge clk);
			if (txd !== 1'b1)
				bad++;
		end
		checks++;
		assert (bad == 0) else begin
			$display("txd left idle after %s", what);
			errors++;
		end
	endtask

	// clear, then read cycles, insts, cycles on the three following cycles
	task automatic clearCheck(input ldStOp_e op);
		pulseRetire(2); // insts nonzero before the clear
		@(posedge clk);
		addr     <= MMIO_CLEAR;
		ldStCtrl <= op;
		@(posedge clk); // counters zeroed here
		addr     <= MMIO_CYCLES;
		ldStCtrl <= LW;
		@(negedge clk);
		checkEq("cycles after clear", rdData, 32'd0);
		@(posedge clk);
		addr <= MMIO_INSTS;
		@(negedge clk);
		checkEq("insts after clear", rdData, 32'd0);
		@(posedge clk);
		addr <= MMIO_CYCLES;
		@(negedge clk);
		checkEq("cycles counting again", rdData, 32'd2); // two edges since the clear
		@(posedge clk);
		addr <= 32'h0;
	endtask

	task automatic pulseRetire(input int k);
		repeat (k) begin
			@(posedge clk);
			instRetire <= 1'b1;
			@(posedge clk);
			instRetire <= 1'b0;
		end
	endtask

	task automatic finishTest(input string name, input int errBefore);
		tests++;
		if (errors == errBefore)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errBefore);
	endtask

	task automatic testReset();
		int e0;
		e0 = errors;
		checkEq("txd", txd, 1'b1);
		expectReg("txReady", MMIO_TX_RDY, 1'b0, 32'd1);
		expectReg("rxValid", MMIO_RX_VLD, 1'b0, 32'd0);
		expectReg("insts", MMIO_INSTS, 1'b0, 32'd0);
		expectReg("tx data word", MMIO_TX_DATA, 1'b0, 32'd0);
		expectReg("addr 0x0", 32'h0000_0000, 1'b0, 32'd0);
		expectReg("addr 0x8000001C", 32'h8000_001C, 1'b0, 32'd0); // just past the map
		expectReg("addr 0x80000002", 32'h8000_0002, 1'b0, 32'd0); // misaligned
		expectReg("addr 0x7FFFFFF0", 32'h7FFF_FFF0, 1'b0, 32'd0);
		clearCheck(LW);
		finishTest("reset", e0);
	endtask

	task automatic testTransmit();
		ldStOp_e     ops [3];
		logic [7:0]  b;
		logic [7:0]  got;
		logic [31:0] d;
		int          k;
		int          e0;
		e0  = errors;
		ops = '{SB, SH, SW}; // every store width
		for (k = 0; k < 3; k++) begin
			b = 8'($random(seed));
			writeReg(MMIO_TX_DATA, ops[k], b);
			fork
				recvTx(got);
				begin
					repeat (3 * CLKS) @(posedge clk); // well inside the frame
					expectReg("txReady mid-frame", MMIO_TX_RDY, 1'b0, 32'd0);
				end
			join
			checkEq("txd byte", got, b);
			waitReg("txReady after frame", MMIO_TX_RDY, 4 * CLKS);
		end
		busCycle(MMIO_TX_DATA, LW, 1'b1, 8'($random(seed)), d);
		checkEq("load of tx data", d, 32'd0);
		expectTxIdle("a load of tx data", 2 * CLKS);
		finishTest("transmit", e0);
	endtask

	task automatic testReceive();
		logic [7:0] b;
		int         e0;
		e0 = errors;
		b  = 8'($random(seed));
		sendRx(b);
		waitReg("rxValid", MMIO_RX_VLD, 2 * CLKS);
		expectReg("rx data peek", MMIO_RX_DATA, 1'b0, {24'd0, b});
		expectReg("rxValid after peek", MMIO_RX_VLD, 1'b0, 32'd1); // no memToReg, not consumed
		expectReg("rx data", MMIO_RX_DATA, 1'b1, {24'd0, b});
		expectReg("rxValid after read", MMIO_RX_VLD, 1'b0, 32'd0);
		finishTest("receive", e0);
	endtask

	task automatic testStall();
		logic [31:0] addrs [7];
		logic [31:0] d;
		logic [31:0] v0;
		logic [31:0] v1;
		logic [31:0] insts0;
		logic [7:0]  b;
		int          i;
		int          e0;
		e0    = errors;
		addrs = '{MMIO_TX_RDY, MMIO_RX_VLD, MMIO_TX_DATA, MMIO_RX_DATA,
			MMIO_CYCLES, MMIO_INSTS, MMIO_CLEAR};
		b     = 8'($random(seed));
		sendRx(b);
		waitReg("rxValid before stall", MMIO_RX_VLD, 2 * CLKS);
		pulseRetire(3); // nonzero insts to watch
		readReg(MMIO_INSTS, 1'b0, insts0);
		readReg(MMIO_CYCLES, 1'b0, v0);
		@(posedge clk);
		stall <= 1'b1;
		for (i = 0; i < 7; i++) begin
			readReg(addrs[i], 1'b1, d); // memToReg high, would consume rx data
			checkEq($sformatf("addr 0x%08h under stall", addrs[i]), d, 32'd0);
		end
		writeReg(MMIO_TX_DATA, SW, ~b);
		expectTxIdle("a store under stall", 2 * CLKS);
		writeReg(MMIO_CLEAR, SW, 8'h00);
		@(posedge clk);
		stall <= 1'b0;
		expectReg("rxValid after stall", MMIO_RX_VLD, 1'b0, 32'd1);
		expectReg("txReady after stall", MMIO_TX_RDY, 1'b0, 32'd1);
		expectReg("insts after stalled clear", MMIO_INSTS, 1'b0, insts0);
		readReg(MMIO_CYCLES, 1'b0, v1);
		checks++;
		assert (v1 > v0) else begin
			$display("cycle counter cleared under stall, %0d then %0d", v0, v1);
			errors++;
		end
		expectReg("rx data after stall", MMIO_RX_DATA, 1'b1, {24'd0, b});
		expectReg("rxValid after read", MMIO_RX_VLD, 1'b0, 32'd0);
		finishTest("stall", e0);
	endtask

	task automatic testCounters();
		logic [31:0] v0;
		logic [31:0] v1;
		int          gap;
		int          k;
		int          e0;
		e0  = errors;
		gap = 4 + ($unsigned($random(seed)) % 20);
		k   = 1 + ($unsigned($random(seed)) % 12);
		readReg(MMIO_CYCLES, 1'b0, v0);
		repeat (gap) @(posedge clk);
		readReg(MMIO_CYCLES, 1'b0, v1);
		checkEq("cycle delta", v1 - v0, gap + 2); // samples sit gap+2 edges apart
		readReg(MMIO_INSTS, 1'b0, v0);
		pulseRetire(k);
		readReg(MMIO_INSTS, 1'b0, v1);
		checkEq("insts delta", v1 - v0, k);
		clearCheck(SW);
		clearCheck(LHU);
		finishTest("counters", e0);
	endtask

	task automatic testOverwrite();
		logic [7:0] b1;
		logic [7:0] b2;
		int         e0;
		e0 = errors;
		b1 = 8'($random(seed));
		b2 = 8'($random(seed));
		if (b2 == b1)
			b2 = ~b1; // must differ to see the overwrite
		sendRx(b1);
		sendRx(b2);
		waitReg("rxValid", MMIO_RX_VLD, 2 * CLKS);
		expectReg("rx data after overwrite", MMIO_RX_DATA, 1'b1, {24'd0, b2});
		expectReg("rxValid after read", MMIO_RX_VLD, 1'b0, 32'd0);
		finishTest("overwrite", e0);
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		addr       = 32'h0;
		wrData     = 8'h00;
		ldStCtrl   = LW;
		memToReg   = 1'b0;
		stall      = 1'b0;
		instRetire = 1'b0;
		rxd        = 1'b1; // line idle
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		testReset();
		testTransmit();
		testReceive();
		testStall();
		testCounters();
		testOverwrite();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
